// File: run_sim.sh
#!/bin/sh
# Build and run the bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_sram_ocp_if \
   -f src.f --Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
   echo "Compile failed"
   exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
   cat sim.log
   echo "Simulation exited with an error"
   exit 1
fi
cat sim.log

if grep -q "^No errors$" sim.log; then
   echo "PASS"
   exit 0
fi
echo "FAIL"
exit 1

// File: source/ocp_sync_fifo.sv
// Show-ahead synchronous FIFO
`timescale 1ns/10ps
`default_nettype none

module ocp_sync_fifo #(
   parameter int DW           = 32,  // Entry width
   parameter int PTRW         = 2,   // Depth is 2**PTRW
   parameter int AFULL_MARGIN = 1    // Free entries kept when almost full
) (
   input  wire logic          clk_i,
   input  wire logic          rst_ni,
   input  wire logic          wr_i,
   input  wire logic [DW-1:0] din_i,
   input  wire logic          rd_i,
   output logic      [DW-1:0] dout_o,
   output logic               empty_o,
   output logic               afull_o
);

   logic [DW-1:0]   mem_q [2**PTRW];  // Storage, no reset
   logic [PTRW-1:0] wr_ptr_q;
   logic [PTRW-1:0] rd_ptr_q;
   logic [PTRW:0]   cnt_q;            // Used entries, one bit wider than pointers

   always_ff @(posedge clk_i)
   begin
      if (wr_i)
         mem_q[wr_ptr_q] <= din_i;
   end

   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         cnt_q    <= '0;
      end
      else
      begin
         if (wr_i)
            wr_ptr_q <= wr_ptr_q + PTRW'(1);
         if (rd_i)
            rd_ptr_q <= rd_ptr_q + PTRW'(1);
         case ({wr_i, rd_i})
            2'b10:   cnt_q <= cnt_q + (PTRW+1)'(1);  // Push only
            2'b01:   cnt_q <= cnt_q - (PTRW+1)'(1);  // Pop only
            default: cnt_q <= cnt_q;                 // Both or neither
         endcase
      end
   end

   // Head entry always visible
   assign dout_o  = mem_q[rd_ptr_q];
   assign empty_o = (cnt_q == '0);
   assign afull_o = (cnt_q >= (PTRW+1)'(2**PTRW - AFULL_MARGIN));

endmodule

`default_nettype wire

// File: source/ram_addr_gen.sv
// SRAM word address generator
`timescale 1ns/10ps
`default_nettype none

module ram_addr_gen import sram_ocp_pkg::*; (
   input  wire logic     clk_i,
   input  wire logic     rst_ni,
   input  wire logic     load_i,      // Start of burst
   input  wire ocp_cmd_t cmd_i,
   input  wire logic     step_i,      // Advance to next beat
   input  wire logic     wrap_i,      // WRAP sequence active
   output ram_addr_t     ram_addr_o,
   output logic          beats_one_o,
   output logic          beats_two_o
);

   ram_addr_t  addr_q;
   burst_len_t cnt_q;     // Beats left, including the one on the SRAM
   logic       grp_end;   // Top word of the wrap group

   assign grp_end = &addr_q[WRAP_GRP_W-1:0];

   //----------------------------------------------------------------------
   // Address and beat counter
   //----------------------------------------------------------------------
   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         addr_q <= '0;
         cnt_q  <= '0;
      end
      else if (load_i)
      begin
         addr_q <= cmd_i.addr[OCP_ADDR_W-1:BYTE_OFS_W];  // Byte to word
         cnt_q  <= cmd_i.blen;
      end
      else if (step_i)
      begin
         cnt_q <= cnt_q - burst_len_t'(1);
         if (wrap_i && grp_end)
            addr_q[WRAP_GRP_W-1:0] <= '0;  // Back to group base
         else
            addr_q <= addr_q + ram_addr_t'(1);
      end
   end

   assign ram_addr_o  = addr_q;
   assign beats_one_o = (cnt_q == burst_len_t'(1));
   assign beats_two_o = (cnt_q == burst_len_t'(2));  // Next step is the last

endmodule

`default_nettype wire

// File: source/read_resp_path.sv
// OCP read response path
`timescale 1ns/10ps
`default_nettype none

module read_resp_path import sram_ocp_pkg::*; (
   input  wire logic      clk_i,
   input  wire logic      rst_ni,
   input  wire logic      ram_en_i,
   input  wire logic      ram_wr_en_i,
   input  wire logic      issue_last_i,
   input  wire ocp_data_t ram_rdata_i,   // Valid one cycle after the read
   input  wire logic      respaccept_i,
   output ocp_resp_e      resp_o,
   output ocp_data_t      data_o,
   output logic           last_o,
   output logic           afull_o
);

   logic     valid_q;   // SRAM data valid this cycle
   logic     last_q;
   logic     rd_empty;
   logic     rd_pop;
   rd_beat_t rd_head;

   // Flags follow the access by one cycle
   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         valid_q <= 1'b0;
         last_q  <= 1'b0;
      end
      else
      begin
         valid_q <= ram_en_i && !ram_wr_en_i;
         last_q  <= issue_last_i;
      end
   end

   ocp_sync_fifo #(
      .DW           ($bits(rd_beat_t)),
      .PTRW         (RD_FIFO_PTRW),
      .AFULL_MARGIN (RD_FIFO_MARGIN)
   ) u_rd_fifo (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .wr_i    (valid_q),
      .din_i   ({last_q, ram_rdata_i}),
      .rd_i    (rd_pop),
      .dout_o  (rd_head),
      .empty_o (rd_empty),
      .afull_o (afull_o)
   );

   // Pop and respond in the same cycle the master accepts
   assign rd_pop = !rd_empty && respaccept_i;
   assign resp_o = rd_pop ? RESP_DVA : RESP_NULL;
   assign data_o = rd_head.data;
   assign last_o = rd_head.last;

endmodule

`default_nettype wire

// File: source/sram_burst_ctrl.sv
// SRAM burst sequencer
`timescale 1ns/10ps
`default_nettype none

module sram_burst_ctrl import sram_ocp_pkg::*; (
   input  wire logic     clk_i,
   input  wire logic     rst_ni,
   input  wire ocp_cmd_t cmd_i,            // Head of command FIFO
   input  wire logic     cmd_empty_i,
   input  wire wr_beat_t wr_beat_i,        // Head of write-data FIFO
   input  wire logic     wr_empty_i,
   input  wire logic     rd_afull_i,       // Response FIFO near full
   input  wire logic     beats_one_i,
   input  wire logic     beats_two_i,
   output logic          cmd_pop_o,
   output logic          wr_pop_o,
   output logic          addr_load_o,
   output logic          addr_step_o,
   output logic          wrap_o,
   output logic          ram_en_o,
   output logic          ram_wr_en_o,
   output ocp_be_t       ram_wr_mask_o,
   output ocp_data_t     ram_wdata_o,
   output logic          rd_issue_o,       // Fresh read, not a held re-read
   output logic          rd_issue_last_o
);

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_INCR_RD,
      ST_INCR_WR,
      ST_WRAP_RD,
      ST_WRAP_WR
   } burst_state_e;

   burst_state_e state_q;

   logic rd_state;
   logic wr_state;
   logic is_wrap;
   logic start_wr;
   logic start_rd;
   logic step_rd;
   logic step_wr;

   //----------------------------------------------------------------------
   // Start and step conditions
   //----------------------------------------------------------------------
   assign rd_state = (state_q == ST_INCR_RD) || (state_q == ST_WRAP_RD);
   assign wr_state = (state_q == ST_INCR_WR) || (state_q == ST_WRAP_WR);
   assign is_wrap  = (cmd_i.bseq == SEQ_WRAP);          // Anything else runs as INCR

   // Write needs its first data beat queued
   assign start_wr = (state_q == ST_IDLE) && !cmd_empty_i && (cmd_i.cmd == CMD_WRITE)
                     && !wr_empty_i;
   // Read waits for room so back-to-back singles cannot overrun
   assign start_rd = (state_q == ST_IDLE) && !cmd_empty_i && (cmd_i.cmd == CMD_READ)
                     && !rd_afull_i;

   assign step_rd = rd_state && !beats_one_i && !rd_afull_i;
   assign step_wr = wr_state && !beats_one_i && !wr_empty_i;

   assign cmd_pop_o   = start_wr || start_rd;
   assign wr_pop_o    = start_wr || step_wr;
   assign addr_load_o = start_wr || start_rd;           // Address loads with first access
   assign addr_step_o = step_rd || step_wr;
   assign wrap_o      = (state_q == ST_WRAP_RD) || (state_q == ST_WRAP_WR);

   //----------------------------------------------------------------------
   // FSM and registered SRAM strobes
   //----------------------------------------------------------------------
   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         state_q         <= ST_IDLE;
         ram_en_o        <= 1'b0;
         ram_wr_en_o     <= 1'b0;
         ram_wr_mask_o   <= '0;
         ram_wdata_o     <= '0;
         rd_issue_o      <= 1'b0;
         rd_issue_last_o <= 1'b0;
      end
      else
      begin
         // Strobes are single-cycle by default
         ram_en_o        <= 1'b0;
         ram_wr_en_o     <= 1'b0;
         ram_wr_mask_o   <= '0;
         ram_wdata_o     <= '0;
         rd_issue_o      <= 1'b0;
         rd_issue_last_o <= 1'b0;
         case (state_q)
            ST_IDLE:
            begin
               if (start_wr)
               begin
                  ram_en_o      <= 1'b1;
                  ram_wr_en_o   <= 1'b1;
                  ram_wr_mask_o <= wr_beat_i.be;
                  ram_wdata_o   <= wr_beat_i.data;
                  state_q       <= is_wrap ? ST_WRAP_WR : ST_INCR_WR;
               end
               else if (start_rd)
               begin
                  ram_en_o        <= 1'b1;
                  rd_issue_o      <= 1'b1;
                  rd_issue_last_o <= (cmd_i.blen == burst_len_t'(1));  // Single beat
                  state_q         <= is_wrap ? ST_WRAP_RD : ST_INCR_RD;
               end
            end
            ST_INCR_RD, ST_WRAP_RD:
            begin
               if (beats_one_i)
                  state_q <= ST_IDLE;                  // Last beat already issued
               else
               begin
                  ram_en_o        <= 1'b1;             // Held re-read while stalled
                  rd_issue_o      <= step_rd;
                  rd_issue_last_o <= step_rd && beats_two_i;
               end
            end
            ST_INCR_WR, ST_WRAP_WR:
            begin
               if (beats_one_i)
                  state_q <= ST_IDLE;
               else if (step_wr)
               begin
                  ram_en_o      <= 1'b1;
                  ram_wr_en_o   <= 1'b1;
                  ram_wr_mask_o <= wr_beat_i.be;
                  ram_wdata_o   <= wr_beat_i.data;
               end
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: source/sram_ocp_if.sv
// OCP slave to SRAM bridge
`timescale 1ns/10ps
`default_nettype none

module sram_ocp_if import sram_ocp_pkg::*; (
   input  wire logic      sram_ocp_clk,
   input  wire logic      sram_ocp_mreset_no,
   // OCP master side
   input  wire ocp_cmd_t  ocp_req_i,
   input  wire logic      ocp_mdatavalid_i,
   input  wire wr_beat_t  ocp_mdata_i,
   input  wire logic      ocp_mrespaccept_i,
   output logic           ocp_scmdaccept_o,
   output logic           ocp_sdataaccept_o,
   output ocp_resp_e      ocp_sresp_o,
   output ocp_data_t      ocp_sdata_o,
   output logic           ocp_sresplast_o,
   // SRAM side
   output ram_addr_t      ram_addr_o,
   output logic           ram_en_o,
   output logic           ram_wr_en_o,
   output ocp_be_t        ram_wr_mask_o,
   output ocp_data_t      ram_wdata_o,
   input  wire ocp_data_t ram_rdata_i
);

   logic     if_en_q;                            // Accepts held off one cycle after reset
   ocp_cmd_t cmd_head;
   wr_beat_t wr_head;
   logic     cmd_push, cmd_pop, cmd_empty, cmd_afull;
   logic     wr_push, wr_pop, wr_empty, wr_afull;
   logic     rd_afull, addr_load, addr_step, wrap;
   logic     beats_one, beats_two, rd_issue, rd_issue_last;

   always_ff @(posedge sram_ocp_clk or negedge sram_ocp_mreset_no)
   begin
      if (!sram_ocp_mreset_no)
         if_en_q <= 1'b0;
      else
         if_en_q <= 1'b1;
   end

   //----------------------------------------------------------------------
   // Accept gating and FIFO writes
   //----------------------------------------------------------------------
   assign ocp_scmdaccept_o  = if_en_q && !cmd_afull;
   assign ocp_sdataaccept_o = if_en_q && !wr_afull;
   assign cmd_push = ((ocp_req_i.cmd == CMD_READ) || (ocp_req_i.cmd == CMD_WRITE))
                     && ocp_scmdaccept_o;
   assign wr_push  = ocp_mdatavalid_i && ocp_sdataaccept_o;

   ocp_sync_fifo #(.DW($bits(ocp_cmd_t)), .PTRW(CMD_FIFO_PTRW),
                   .AFULL_MARGIN(CMD_FIFO_MARGIN)) u_cmd_fifo (
      .clk_i (sram_ocp_clk), .rst_ni (sram_ocp_mreset_no), .wr_i (cmd_push),
      .din_i (ocp_req_i), .rd_i (cmd_pop), .dout_o (cmd_head),
      .empty_o (cmd_empty), .afull_o (cmd_afull)
   );

   ocp_sync_fifo #(.DW($bits(wr_beat_t)), .PTRW(WR_FIFO_PTRW),
                   .AFULL_MARGIN(WR_FIFO_MARGIN)) u_wr_fifo (
      .clk_i (sram_ocp_clk), .rst_ni (sram_ocp_mreset_no), .wr_i (wr_push),
      .din_i (ocp_mdata_i), .rd_i (wr_pop), .dout_o (wr_head),
      .empty_o (wr_empty), .afull_o (wr_afull)
   );

   sram_burst_ctrl u_ctrl (
      .clk_i (sram_ocp_clk), .rst_ni (sram_ocp_mreset_no),
      .cmd_i (cmd_head), .cmd_empty_i (cmd_empty), .wr_beat_i (wr_head),
      .wr_empty_i (wr_empty), .rd_afull_i (rd_afull), .beats_one_i (beats_one),
      .beats_two_i (beats_two), .cmd_pop_o (cmd_pop), .wr_pop_o (wr_pop),
      .addr_load_o (addr_load), .addr_step_o (addr_step), .wrap_o (wrap),
      .ram_en_o (ram_en_o), .ram_wr_en_o (ram_wr_en_o), .ram_wr_mask_o (ram_wr_mask_o),
      .ram_wdata_o (ram_wdata_o), .rd_issue_o (rd_issue), .rd_issue_last_o (rd_issue_last)
   );

   ram_addr_gen u_addr (
      .clk_i (sram_ocp_clk), .rst_ni (sram_ocp_mreset_no), .load_i (addr_load),
      .cmd_i (cmd_head), .step_i (addr_step), .wrap_i (wrap), .ram_addr_o (ram_addr_o),
      .beats_one_o (beats_one), .beats_two_o (beats_two)
   );

   // Only fresh read issues reach the response FIFO
   read_resp_path u_rd_path (
      .clk_i (sram_ocp_clk), .rst_ni (sram_ocp_mreset_no), .ram_en_i (rd_issue),
      .ram_wr_en_i (ram_wr_en_o), .issue_last_i (rd_issue_last), .ram_rdata_i (ram_rdata_i),
      .respaccept_i (ocp_mrespaccept_i), .resp_o (ocp_sresp_o), .data_o (ocp_sdata_o),
      .last_o (ocp_sresplast_o), .afull_o (rd_afull)
   );

endmodule

`default_nettype wire

// File: source/sram_ocp_pkg.sv
// SRAM OCP bridge definitions
`default_nettype none

package sram_ocp_pkg;

   //----------------------------------------------------------------------
   // Widths
   //----------------------------------------------------------------------
   localparam int OCP_ADDR_W  = 24;                       // Byte address
   localparam int OCP_DATA_W  = 32;
   localparam int OCP_BE_W    = 4;                        // Bytes per word
   localparam int BYTE_OFS_W  = 2;                        // Dropped from byte address
   localparam int BURST_LEN_W = 8;
   localparam int RAM_ADDR_W  = OCP_ADDR_W - BYTE_OFS_W;  // Word address
   localparam int WRAP_GRP_W  = 2;                        // Wrap group of four words

   // FIFO sizing
   localparam int CMD_FIFO_PTRW   = 2;
   localparam int CMD_FIFO_MARGIN = 1;
   localparam int WR_FIFO_PTRW    = 2;
   localparam int WR_FIFO_MARGIN  = 1;
   localparam int RD_FIFO_PTRW    = 3;
   localparam int RD_FIFO_MARGIN  = 2;  // Beat in SRAM plus registered enable

   typedef logic [OCP_ADDR_W-1:0]  ocp_addr_t;
   typedef logic [OCP_DATA_W-1:0]  ocp_data_t;
   typedef logic [OCP_BE_W-1:0]    ocp_be_t;
   typedef logic [BURST_LEN_W-1:0] burst_len_t;
   typedef logic [RAM_ADDR_W-1:0]  ram_addr_t;

   //----------------------------------------------------------------------
   // OCP encodings
   //----------------------------------------------------------------------
   typedef enum logic [2:0] {CMD_IDLE = 3'd0, CMD_WRITE = 3'd1, CMD_READ = 3'd2} ocp_cmd_e;
   typedef enum logic [2:0] {SEQ_INCR = 3'd0, SEQ_WRAP = 3'd2} burst_seq_e;
   typedef enum logic [1:0] {RESP_NULL = 2'd0, RESP_DVA = 2'd1} ocp_resp_e;

   // Command as queued in the command FIFO
   typedef struct packed {
      burst_seq_e bseq;
      burst_len_t blen;
      ocp_cmd_e   cmd;
      ocp_addr_t  addr;
   } ocp_cmd_t;

   typedef struct packed {
      ocp_be_t   be;    // Byte enables, also the SRAM write mask
      ocp_data_t data;
   } wr_beat_t;

   typedef struct packed {
      logic      last;  // Final beat of the read burst
      ocp_data_t data;
   } rd_beat_t;

endpackage

`default_nettype wire

// File: src.f
source/sram_ocp_pkg.sv
source/ocp_sync_fifo.sv
source/ram_addr_gen.sv
source/read_resp_path.sv
source/sram_burst_ctrl.sv
source/sram_ocp_if.sv
testbench/tb_sram_ocp_if.sv

// File: testbench/tb_sram_ocp_if.sv
// OCP SRAM bridge testbench
`timescale 1ns/10ps
`default_nettype none

module tb_sram_ocp_if import sram_ocp_pkg::*; ();

   localparam int CLK_HALF        = 10;               // 20 ns period
   localparam int MEM_WORDS       = 1024;             // Modelled part of the SRAM
   localparam int TOTAL_BEATS     = 100;              // All read and write beats, rounded up
   localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 40 + 500;
   localparam int WAIT_LIMIT      = 400;              // Cycles for any single handshake

   logic      sram_ocp_clk;
   logic      sram_ocp_mreset_no;
   ocp_cmd_t  ocp_req;
   logic      ocp_mdatavalid;
   wr_beat_t  ocp_mdata;
   logic      ocp_mrespaccept;
   logic      ocp_scmdaccept;
   logic      ocp_sdataaccept;
   ocp_resp_e ocp_sresp;
   ocp_data_t ocp_sdata;
   logic      ocp_sresplast;
   ram_addr_t ram_addr;
   logic      ram_en;
   logic      ram_wr_en;
   ocp_be_t   ram_wr_mask;
   ocp_data_t ram_wdata;
   ocp_data_t ram_rdata;

   ocp_data_t sram_mem [MEM_WORDS];   // SRAM model storage
   ocp_data_t shadow   [MEM_WORDS];   // Expected contents
   rd_beat_t  exp_rd_q [$];           // Expected responses in order
   ram_addr_t exp_wr_q [$];           // Expected write addresses
   wr_beat_t  pend_q   [$];           // Write beats not yet sent
   rd_beat_t  exp_beat;
   ram_addr_t exp_addr;
   logic      rand_accept;
   int        errors;
   int        i;

   sram_ocp_if uut (
      .sram_ocp_clk       (sram_ocp_clk),
      .sram_ocp_mreset_no (sram_ocp_mreset_no),
      .ocp_req_i          (ocp_req),
      .ocp_mdatavalid_i   (ocp_mdatavalid),
      .ocp_mdata_i        (ocp_mdata),
      .ocp_mrespaccept_i  (ocp_mrespaccept),
      .ocp_scmdaccept_o   (ocp_scmdaccept),
      .ocp_sdataaccept_o  (ocp_sdataaccept),
      .ocp_sresp_o        (ocp_sresp),
      .ocp_sdata_o        (ocp_sdata),
      .ocp_sresplast_o    (ocp_sresplast),
      .ram_addr_o         (ram_addr),
      .ram_en_o           (ram_en),
      .ram_wr_en_o        (ram_wr_en),
      .ram_wr_mask_o      (ram_wr_mask),
      .ram_wdata_o        (ram_wdata),
      .ram_rdata_i        (ram_rdata)
   );

   initial
   begin
      sram_ocp_clk = 1'b0;
      forever #CLK_HALF sram_ocp_clk = ~sram_ocp_clk;
   end

   //----------------------------------------------------------------------
   // Helpers
   //----------------------------------------------------------------------
   function automatic ocp_data_t fill_word(int idx);
      return 32'hA5C3_0000 ^ (32'(idx) * 32'h9E37_79B1);  // Whole address matters
   endfunction

   function automatic ocp_data_t merge_bytes(ocp_data_t old_w, ocp_data_t new_w, ocp_be_t be);
      ocp_data_t res;
      res = old_w;
      for (int b = 0; b < OCP_BE_W; b++)
         if (be[b])
            res[b*8 +: 8] = new_w[b*8 +: 8];
      return res;
   endfunction

   // INCR counts up, WRAP stays inside its aligned group of four
   function automatic ram_addr_t beat_addr(ram_addr_t start, int beat, logic wrap);
      ram_addr_t a;
      if (wrap)
      begin
         a      = start;
         a[1:0] = start[1:0] + 2'(beat);
      end
      else
         a = start + ram_addr_t'(beat);
      return a;
   endfunction

   task automatic report_mismatch(string name, logic [31:0] exp_v, logic [31:0] act_v);
      $display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp_v, act_v);
      errors++;
   endtask

   task automatic check_idle();
      assert (!ocp_scmdaccept) else report_mismatch("ocp_scmdaccept_o", 0, 32'(ocp_scmdaccept));
      assert (!ocp_sdataaccept) else report_mismatch("ocp_sdataaccept_o", 0, 32'(ocp_sdataaccept));
      assert (!ram_en) else report_mismatch("ram_en_o", 0, 32'(ram_en));
      assert (!ram_wr_en) else report_mismatch("ram_wr_en_o", 0, 32'(ram_wr_en));
      assert (ocp_sresp == RESP_NULL) else report_mismatch("ocp_sresp_o", 0, 32'(ocp_sresp));
   endtask

   // Drive one command once the slave can take it
   task automatic send_cmd(ocp_cmd_e c, ram_addr_t word, int len, burst_seq_e seq);
      int waited;
      waited = 0;
      @(negedge sram_ocp_clk);
      while (!ocp_scmdaccept && waited < WAIT_LIMIT)
      begin
         waited++;
         @(negedge sram_ocp_clk);
      end
      if (!ocp_scmdaccept)
      begin
         $display("Command accept never came at %0t ns", $time);
         errors++;
      end
      ocp_req.cmd  = c;
      ocp_req.addr = {word, 2'($urandom)};    // Byte offset is ignored
      ocp_req.blen = burst_len_t'(len);
      ocp_req.bseq = seq;
      @(negedge sram_ocp_clk);
      ocp_req.cmd  = CMD_IDLE;
   endtask

   task automatic send_data(wr_beat_t beat);
      int waited;
      waited = 0;
      @(negedge sram_ocp_clk);
      while (!ocp_sdataaccept && waited < WAIT_LIMIT)
      begin
         waited++;
         @(negedge sram_ocp_clk);
      end
      if (!ocp_sdataaccept)
      begin
         $display("Data accept never came at %0t ns", $time);
         errors++;
      end
      ocp_mdatavalid = 1'b1;
      ocp_mdata      = beat;
      @(negedge sram_ocp_clk);
      ocp_mdatavalid = 1'b0;
   endtask

   // Queue the beats, update shadow, then send only the command
   task automatic write_burst(int word, int len, burst_seq_e seq, logic rand_mask);
      wr_beat_t  beat;
      ram_addr_t a;
      for (int k = 0; k < len; k++)
      begin
         a         = beat_addr(ram_addr_t'(word), k, seq == SEQ_WRAP);
         beat.data = $urandom;
         beat.be   = rand_mask ? ocp_be_t'($urandom) : '1;
         shadow[a[9:0]] = merge_bytes(shadow[a[9:0]], beat.data, beat.be);
         exp_wr_q.push_back(a);
         pend_q.push_back(beat);
      end
      send_cmd(CMD_WRITE, ram_addr_t'(word), len, seq);
   endtask

   task automatic flush_data();
      while (pend_q.size() > 0)
         send_data(pend_q.pop_front());
   endtask

   task automatic read_burst(int word, int len, burst_seq_e seq);
      rd_beat_t  beat;
      ram_addr_t a;
      for (int k = 0; k < len; k++)
      begin
         a         = beat_addr(ram_addr_t'(word), k, seq == SEQ_WRAP);
         beat.data = shadow[a[9:0]];
         beat.last = (k == len - 1);  // Last only on final beat
         exp_rd_q.push_back(beat);
      end
      send_cmd(CMD_READ, ram_addr_t'(word), len, seq);
   endtask

   task automatic wait_done();
      int waited;
      waited = 0;
      while ((exp_rd_q.size() > 0 || exp_wr_q.size() > 0) && waited < WAIT_LIMIT)
      begin
         waited++;
         @(negedge sram_ocp_clk);
      end
      if (exp_rd_q.size() > 0 || exp_wr_q.size() > 0)
      begin
         $display("Outstanding beats not completed at %0t ns", $time);
         errors++;
      end
   endtask

   //----------------------------------------------------------------------
   // SRAM model and monitors
   //----------------------------------------------------------------------
   always @(posedge sram_ocp_clk)
   begin
      if (ram_en && ram_wr_en)
         sram_mem[ram_addr[9:0]] <= merge_bytes(sram_mem[ram_addr[9:0]], ram_wdata, ram_wr_mask);
      else if (ram_en)
         ram_rdata <= sram_mem[ram_addr[9:0]];  // One cycle latency
   end

   always @(posedge sram_ocp_clk)
   begin
      if (sram_ocp_mreset_no && ram_en && ram_wr_en)
      begin
         if (exp_wr_q.size() == 0)
         begin
            $display("Unexpected SRAM write at %0t ns", $time);
            errors++;
         end
         else
         begin
            exp_addr = exp_wr_q.pop_front();
            assert (ram_addr == exp_addr)
               else report_mismatch("ram_addr_o", 32'(exp_addr), 32'(ram_addr));
         end
      end
   end

   always @(posedge sram_ocp_clk)
   begin
      if (sram_ocp_mreset_no && ocp_sresp == RESP_DVA)
      begin
         assert (ocp_mrespaccept) else report_mismatch("ocp_mrespaccept_i", 1, 0);
         if (exp_rd_q.size() == 0)
         begin
            $display("Read response with no read outstanding at %0t ns", $time);
            errors++;
         end
         else
         begin
            exp_beat = exp_rd_q.pop_front();
            assert (ocp_sdata == exp_beat.data)
               else report_mismatch("ocp_sdata_o", exp_beat.data, ocp_sdata);
            assert (ocp_sresplast == exp_beat.last)
               else report_mismatch("ocp_sresplast_o", 32'(exp_beat.last), 32'(ocp_sresplast));
         end
      end
   end

   // Master response accept, random in the back-pressure test
   always @(negedge sram_ocp_clk)
      ocp_mrespaccept <= rand_accept ? 1'($urandom) : 1'b1;

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge sram_ocp_clk);
      $display("Watchdog expired before the tests finished");
      $display("Error count: %0d", errors);
      $display("Errors found");
      $finish;
   end

   //----------------------------------------------------------------------
   // Test sequence
   //----------------------------------------------------------------------
   initial
   begin
      void'($urandom(32'h2853));
      sram_ocp_mreset_no = 1'b0;
      ocp_req            = '0;
      ocp_req.cmd        = CMD_IDLE;
      ocp_mdatavalid     = 1'b0;
      ocp_mdata          = '0;
      ocp_mrespaccept    = 1'b1;
      ram_rdata          = '0;
      rand_accept        = 1'b0;
      errors             = 0;
      for (i = 0; i < MEM_WORDS; i++)
      begin
         sram_mem[i] <= fill_word(i);
         shadow[i]    = fill_word(i);
      end
      repeat (4)
      begin
         @(negedge sram_ocp_clk);
         check_idle();
      end
      sram_ocp_mreset_no = 1'b1;
      check_idle();                         // Accepts still held off

      // Single writes with random masks
      for (i = 0; i < 8; i++)
      begin
         write_burst(10 + 3 * i, 1, SEQ_INCR, 1'b1);
         flush_data();
      end
      for (i = 0; i < 8; i++)
         read_burst(10 + 3 * i, 1, SEQ_INCR);
      wait_done();

      // INCR burst of eight
      write_burst(200, 8, SEQ_INCR, 1'b0);
      flush_data();
      read_burst(200, 8, SEQ_INCR);
      wait_done();

      // WRAP of four from offset 2
      write_burst(66, 4, SEQ_WRAP, 1'b0);
      flush_data();
      read_burst(66, 4, SEQ_WRAP);
      wait_done();

      // Random response back-pressure
      rand_accept = 1'b1;
      read_burst(200, 8, SEQ_INCR);
      for (i = 0; i < 4; i++)
         read_burst(10 + 3 * i, 1, SEQ_INCR);
      read_burst(66, 4, SEQ_WRAP);
      wait_done();
      rand_accept = 1'b0;

      // Commands queued while data is withheld
      for (i = 0; i < 3; i++)
         write_burst(300 + i, 1, SEQ_INCR, 1'b1);
      assert (!ocp_scmdaccept) else report_mismatch("ocp_scmdaccept_o", 0, 1);
      flush_data();
      for (i = 0; i < 3; i++)
         read_burst(300 + i, 1, SEQ_INCR);
      wait_done();

      repeat (4) @(negedge sram_ocp_clk);
      $display("Error count: %0d", errors);
      if (errors == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule

`default_nettype wire
